// File: verilog/sysctl_map_pkg.sv
// address map, register offsets and reset values shared by the APB system-control blocks
`default_nettype none

package sysctl_map_pkg;

	// APB bus widths
	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	// region windows on the APB bus
	localparam logic [APB_ADDR_W-1:0] SYSCTL_BASE  = 12'h000;
	localparam logic [APB_ADDR_W-1:0] SYSCTL_LIMIT = 12'h0FF;
	localparam logic [APB_ADDR_W-1:0] MBOX_BASE    = 12'h100;
	localparam logic [APB_ADDR_W-1:0] MBOX_LIMIT   = 12'h1FF;

	// control register offsets
	localparam logic [APB_ADDR_W-1:0] REG_LED    = 12'h000;
	localparam logic [APB_ADDR_W-1:0] REG_ACTIVE = 12'h004;
	localparam logic [APB_ADDR_W-1:0] REG_IDLE   = 12'h008;
	localparam logic [APB_ADDR_W-1:0] REG_RESET  = 12'h00C;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 12'h010;

	// mailbox offsets
	localparam logic [APB_ADDR_W-1:0] MBOX_DATA = 12'h000;
	localparam logic [APB_ADDR_W-1:0] MBOX_STAT = 12'h004;

	// MBOX_STAT layout: count in the low byte, then empty and full flags
	localparam int MBOX_CNT_W      = 8;
	localparam int MBOX_STAT_EMPTY = 8;
	localparam int MBOX_STAT_FULL  = 9;

	localparam int LED_W = 4;

	localparam int unsigned IDLE_RESET_VAL   = 200;
	localparam int unsigned ACTIVE_RESET_VAL = 0;

	// 8 words deep
	localparam int MBOX_DEPTH_BITS = 3;

endpackage

`default_nettype wire

// File: verilog/rst_seq_pkg.sv
// core reset sequencer state encoding and counter width, used by the sequencer and its counter
`default_nettype none

package rst_seq_pkg;

	// wide enough for any IDLE or ACTIVE value written over APB
	localparam int SEQ_CNT_W = 32;

	// sequencer states
	typedef enum logic [0:0] {
		// core held in reset for IDLE+1 cycles
		SEQ_HOLD = 1'b0,
		// core running, optionally for ACTIVE+1 cycles
		SEQ_RUN  = 1'b1
	} seq_state_t;

endpackage

`default_nettype wire

// File: verilog/apb_region_decoder.sv
// APB address decoder that selects a region and returns its response, or an error when unmapped
`default_nettype none

module apb_region_decoder (
	input  wire                                   i_psel,
	input  wire                                   i_penable,
	input  wire  [sysctl_map_pkg::APB_ADDR_W-1:0] i_paddr,
	input  wire  [sysctl_map_pkg::APB_DATA_W-1:0] i_sysctl_prdata,
	input  wire                                   i_sysctl_pslverr,
	input  wire  [sysctl_map_pkg::APB_DATA_W-1:0] i_mbox_prdata,
	input  wire                                   i_mbox_pslverr,
	output logic                                  o_sysctl_psel,
	output logic                                  o_mbox_psel,
	output logic [sysctl_map_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                                  o_pready,
	output logic                                  o_pslverr
);
	import sysctl_map_pkg::*;

	logic sysctl_hit;
	logic mbox_hit;
	logic access;

	// region match on the full address
	assign sysctl_hit = (i_paddr >= SYSCTL_BASE) && (i_paddr <= SYSCTL_LIMIT);
	assign mbox_hit   = (i_paddr >= MBOX_BASE) && (i_paddr <= MBOX_LIMIT);

	assign o_sysctl_psel = i_psel & sysctl_hit;
	assign o_mbox_psel   = i_psel & mbox_hit;

	// every target completes in the access phase, no wait states
	assign access   = i_psel & i_penable;
	assign o_pready = access;

	// response mux, decoder answers unmapped accesses itself
	always_comb begin
		o_prdata  = '0;
		o_pslverr = 1'b0;
		if (access) begin
			if (sysctl_hit) begin
				o_prdata  = i_sysctl_prdata;
				o_pslverr = i_sysctl_pslverr;
			end else if (mbox_hit) begin
				o_prdata  = i_mbox_prdata;
				o_pslverr = i_mbox_pslverr;
			end else begin
				// unmapped: zero data with error
				o_pslverr = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/sysctl_regs.sv
// APB control registers for the LEDs, reset sequencer timing, software reset and core status
`default_nettype none

module sysctl_regs (
	input  wire                                   core_clk,
	input  wire                                   rst_n,
	input  wire                                   i_psel,
	input  wire                                   i_penable,
	input  wire                                   i_pwrite,
	input  wire  [sysctl_map_pkg::APB_ADDR_W-1:0] i_paddr,
	input  wire  [sysctl_map_pkg::APB_DATA_W-1:0] i_pwdata,
	input  wire                                   i_core_in_rst,
	output logic [sysctl_map_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                                  o_pslverr,
	output logic [sysctl_map_pkg::LED_W-1:0]      o_led,
	output logic [rst_seq_pkg::SEQ_CNT_W-1:0]     o_idle,
	output logic [rst_seq_pkg::SEQ_CNT_W-1:0]     o_active,
	output logic                                  o_rst_req
);
	import sysctl_map_pkg::*;
	import rst_seq_pkg::*;

	logic [APB_ADDR_W-1:0] offset;
	logic                  access;
	logic                  wr_en;
	logic                  known;

	assign offset = i_paddr - SYSCTL_BASE;
	assign access = i_psel & i_penable;
	assign wr_en  = access & i_pwrite;

	// STATUS is read-only, anything else off the map is an error
	always_comb begin
		case (offset)
			REG_LED, REG_ACTIVE, REG_IDLE, REG_RESET: known = 1'b1;
			REG_STATUS: known = ~i_pwrite;
			default: known = 1'b0;
		endcase
	end

	assign o_pslverr = access & ~known;

	// read data straight from the registers
	always_comb begin
		o_prdata = '0;
		if (access && !i_pwrite) begin
			case (offset)
				REG_LED:    o_prdata = APB_DATA_W'(o_led);
				REG_ACTIVE: o_prdata = APB_DATA_W'(o_active);
				REG_IDLE:   o_prdata = APB_DATA_W'(o_idle);
				REG_STATUS: o_prdata = APB_DATA_W'(i_core_in_rst);
				// RESET reads as zero
				default:    o_prdata = '0;
			endcase
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			o_led     <= '0;
			o_idle    <= SEQ_CNT_W'(IDLE_RESET_VAL);
			o_active  <= SEQ_CNT_W'(ACTIVE_RESET_VAL);
			o_rst_req <= 1'b0;
		end else begin
			// single-cycle request, any write value
			o_rst_req <= wr_en && (offset == REG_RESET);
			if (wr_en) begin
				case (offset)
					REG_LED:    o_led    <= i_pwdata[LED_W-1:0];
					REG_ACTIVE: o_active <= i_pwdata[SEQ_CNT_W-1:0];
					REG_IDLE:   o_idle   <= i_pwdata[SEQ_CNT_W-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/cycle_counter.sv
// restartable up-counter that stops and flags a hit when it reaches the given limit
`default_nettype none

module cycle_counter (
	input  wire                               core_clk,
	input  wire                               rst_n,
	input  wire                               i_restart,
	input  wire  [rst_seq_pkg::SEQ_CNT_W-1:0] i_limit,
	output logic                              o_hit
);
	import rst_seq_pkg::*;

	logic [SEQ_CNT_W-1:0] count;

	assign o_hit = (count == i_limit);

	// holds at the limit so the hit stays up until the next restart
	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (i_restart) begin
			count <= '0;
		end else if (!o_hit) begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/core_rst_sequencer.sv
// HOLD/RUN state machine that holds the managed core in reset and releases it on a timed schedule
`default_nettype none

module core_rst_sequencer (
	input  wire                               core_clk,
	input  wire                               rst_n,
	input  wire  [rst_seq_pkg::SEQ_CNT_W-1:0] i_idle,
	input  wire  [rst_seq_pkg::SEQ_CNT_W-1:0] i_active,
	input  wire                               i_rst_req,
	output logic                              o_core_rst_n,
	output logic                              o_core_in_rst
);
	import rst_seq_pkg::*;

	seq_state_t           state_q;
	seq_state_t           state_d;
	logic [SEQ_CNT_W-1:0] limit;
	logic                 restart;
	logic                 hit;
	logic                 active_on;

	// zero ACTIVE means the core runs until software resets it
	assign active_on = (i_active != '0);
	assign limit     = (state_q == SEQ_HOLD) ? i_idle : i_active;

	cycle_counter u_cnt (
		.core_clk  (core_clk),
		.rst_n     (rst_n),
		.i_restart (restart),
		.i_limit   (limit),
		.o_hit     (hit)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			SEQ_HOLD: begin
				if (hit) begin
					state_d = SEQ_RUN;
				end
			end
			SEQ_RUN: begin
				if (i_rst_req || (active_on && hit)) begin
					state_d = SEQ_HOLD;
				end
			end
			default: state_d = SEQ_HOLD;
		endcase
	end

	// new state starts counting from zero
	assign restart = (state_d != state_q);

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			state_q      <= SEQ_HOLD;
			o_core_rst_n <= 1'b0;
		end else begin
			state_q      <= state_d;
			o_core_rst_n <= (state_d == SEQ_RUN);
		end
	end

	assign o_core_in_rst = (state_q == SEQ_HOLD);

endmodule

`default_nettype wire

// File: verilog/apb_mailbox.sv
// APB mailbox FIFO where the host pushes and pops words, with a not-empty interrupt
`default_nettype none

module apb_mailbox #(
	parameter int DEPTH_BITS = sysctl_map_pkg::MBOX_DEPTH_BITS
) (
	input  wire                                   core_clk,
	input  wire                                   rst_n,
	input  wire                                   i_psel,
	input  wire                                   i_penable,
	input  wire                                   i_pwrite,
	input  wire  [sysctl_map_pkg::APB_ADDR_W-1:0] i_paddr,
	input  wire  [sysctl_map_pkg::APB_DATA_W-1:0] i_pwdata,
	output logic [sysctl_map_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                                  o_pslverr,
	output logic                                  o_irq
);
	import sysctl_map_pkg::*;

	localparam int DEPTH = 2 ** DEPTH_BITS;

	logic [APB_DATA_W-1:0] mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic [APB_ADDR_W-1:0] offset;
	logic                  access;
	logic                  is_data;
	logic                  is_stat;
	logic                  empty;
	logic                  full;
	logic                  push;
	logic                  pop;

	assign offset  = i_paddr - MBOX_BASE;
	assign access  = i_psel & i_penable;
	assign is_data = (offset == MBOX_DATA);
	assign is_stat = (offset == MBOX_STAT);

	assign empty = (count == '0);
	assign full  = (count == (DEPTH_BITS + 1)'(DEPTH));

	// overflow and underflow leave the FIFO untouched
	assign push = access & i_pwrite & is_data & ~full;
	assign pop  = access & ~i_pwrite & is_data & ~empty;

	assign o_pslverr = access & ((is_data & (i_pwrite ? full : empty)) |
		(is_stat & i_pwrite) | (~is_data & ~is_stat));

	always_comb begin
		o_prdata = '0;
		if (pop) begin
			o_prdata = mem[rd_ptr];
		end else if (access && !i_pwrite && is_stat) begin
			o_prdata[MBOX_CNT_W-1:0]  = MBOX_CNT_W'(count);
			o_prdata[MBOX_STAT_EMPTY] = empty;
			o_prdata[MBOX_STAT_FULL]  = full;
		end
	end

	always_ff @(posedge core_clk) begin
		if (push) begin
			mem[wr_ptr] <= i_pwdata;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign o_irq = ~empty;

endmodule

`default_nettype wire

// File: verilog/sysctl_subsys.sv
// system-control subsystem top that joins the APB decoder, control registers, sequencer and mailbox
`default_nettype none

module sysctl_subsys (
	input  wire                                  core_clk,
	input  wire                                  rst_n,
	input  wire                                  i_psel,
	input  wire                                  i_penable,
	input  wire                                  i_pwrite,
	input  wire [sysctl_map_pkg::APB_ADDR_W-1:0] i_paddr,
	input  wire [sysctl_map_pkg::APB_DATA_W-1:0] i_pwdata,
	output wire [sysctl_map_pkg::APB_DATA_W-1:0] o_prdata,
	output wire                                  o_pready,
	output wire                                  o_pslverr,
	output wire                                  o_core_rst_n,
	output wire [sysctl_map_pkg::LED_W-1:0]      o_led,
	output wire                                  o_mbox_irq
);
	import sysctl_map_pkg::*;
	import rst_seq_pkg::*;

	// per-region selects and responses
	logic                  sysctl_psel;
	logic                  mbox_psel;
	logic [APB_DATA_W-1:0] sysctl_prdata;
	logic                  sysctl_pslverr;
	logic [APB_DATA_W-1:0] mbox_prdata;
	logic                  mbox_pslverr;

	// register block to sequencer
	logic [SEQ_CNT_W-1:0]  idle;
	logic [SEQ_CNT_W-1:0]  active;
	logic                  rst_req;
	logic                  core_in_rst;

	apb_region_decoder u_decoder (
		.i_psel           (i_psel),
		.i_penable        (i_penable),
		.i_paddr          (i_paddr),
		.i_sysctl_prdata  (sysctl_prdata),
		.i_sysctl_pslverr (sysctl_pslverr),
		.i_mbox_prdata    (mbox_prdata),
		.i_mbox_pslverr   (mbox_pslverr),
		.o_sysctl_psel    (sysctl_psel),
		.o_mbox_psel      (mbox_psel),
		.o_prdata         (o_prdata),
		.o_pready         (o_pready),
		.o_pslverr        (o_pslverr)
	);

	sysctl_regs u_regs (
		.core_clk      (core_clk),
		.rst_n         (rst_n),
		.i_psel        (sysctl_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.i_core_in_rst (core_in_rst),
		.o_prdata      (sysctl_prdata),
		.o_pslverr     (sysctl_pslverr),
		.o_led         (o_led),
		.o_idle        (idle),
		.o_active      (active),
		.o_rst_req     (rst_req)
	);

	core_rst_sequencer u_seq (
		.core_clk      (core_clk),
		.rst_n         (rst_n),
		.i_idle        (idle),
		.i_active      (active),
		.i_rst_req     (rst_req),
		.o_core_rst_n  (o_core_rst_n),
		.o_core_in_rst (core_in_rst)
	);

	apb_mailbox #(
		.DEPTH_BITS (MBOX_DEPTH_BITS)
	) u_mbox (
		.core_clk  (core_clk),
		.rst_n     (rst_n),
		.i_psel    (mbox_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (mbox_prdata),
		.o_pslverr (mbox_pslverr),
		.o_irq     (o_mbox_irq)
	);

endmodule

`default_nettype wire

// File: test/sysctl_assertions.sv
// APB protocol, core reset and mailbox interrupt assertions, bound into the subsystem top
`default_nettype none

module sysctl_assertions (
	input wire                                  core_clk,
	input wire                                  rst_n,
	input wire                                  i_psel,
	input wire                                  i_penable,
	input wire                                  i_pwrite,
	input wire [sysctl_map_pkg::APB_ADDR_W-1:0] i_paddr,
	input wire                                  o_pready,
	input wire                                  o_pslverr,
	input wire                                  o_core_rst_n,
	input wire                                  o_mbox_irq
);
	import sysctl_map_pkg::*;

	logic [MBOX_DEPTH_BITS:0] occupancy;
	logic                     data_xfer;

	// successful transfers to the mailbox data port
	assign data_xfer = i_psel & i_penable & (i_paddr == (MBOX_BASE + MBOX_DATA)) & ~o_pslverr;

	// word count seen from the bus side
	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			occupancy <= '0;
		end else if (data_xfer) begin
			occupancy <= i_pwrite ? occupancy + 1'b1 : occupancy - 1'b1;
		end
	end

	// a setup phase is followed by an access phase that completes at once
	a_pready_in_access: assert property (@(posedge core_clk) disable iff (!rst_n)
		(i_psel && !i_penable) |=> (i_psel && i_penable && o_pready))
		else $error("setup phase not followed by an access phase with pready high");

	a_pslverr_with_pready: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_pslverr |-> o_pready)
		else $error("pslverr without pready");

	a_core_rst_follows: assert property (@(posedge core_clk)
		!rst_n |=> !o_core_rst_n)
		else $error("core reset not asserted after rst_n");

	a_irq_not_empty: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_mbox_irq == (occupancy != '0))
		else $error("mailbox irq does not match occupancy");

endmodule

bind sysctl_subsys sysctl_assertions u_assert (
	.core_clk     (core_clk),
	.rst_n        (rst_n),
	.i_psel       (i_psel),
	.i_penable    (i_penable),
	.i_pwrite     (i_pwrite),
	.i_paddr      (i_paddr),
	.o_pready     (o_pready),
	.o_pslverr    (o_pslverr),
	.o_core_rst_n (o_core_rst_n),
	.o_mbox_irq   (o_mbox_irq)
);

`default_nettype wire

// File: test/tb_sysctl_subsys.sv
// testbench for the system-control subsystem, run as the simulation top with compile.f
`default_nettype none

module tb_sysctl_subsys;
	import sysctl_map_pkg::*;

	localparam logic [APB_ADDR_W-1:0] A_LED    = SYSCTL_BASE + REG_LED;
	localparam logic [APB_ADDR_W-1:0] A_ACTIVE = SYSCTL_BASE + REG_ACTIVE;
	localparam logic [APB_ADDR_W-1:0] A_IDLE   = SYSCTL_BASE + REG_IDLE;
	localparam logic [APB_ADDR_W-1:0] A_RESET  = SYSCTL_BASE + REG_RESET;
	localparam logic [APB_ADDR_W-1:0] A_STATUS = SYSCTL_BASE + REG_STATUS;
	localparam logic [APB_ADDR_W-1:0] A_MDATA  = MBOX_BASE + MBOX_DATA;
	localparam logic [APB_ADDR_W-1:0] A_MSTAT  = MBOX_BASE + MBOX_STAT;

	typedef struct packed {
		logic                  wr;
		logic [APB_ADDR_W-1:0] addr;
		logic [APB_DATA_W-1:0] wdata;
		logic [APB_DATA_W-1:0] rdata;
		logic                  err;
	} row_t;

	logic                  core_clk;
	logic                  rst_n;
	logic                  i_psel;
	logic                  i_penable;
	logic                  i_pwrite;
	logic [APB_ADDR_W-1:0] i_paddr;
	logic [APB_DATA_W-1:0] i_pwdata;
	wire  [APB_DATA_W-1:0] o_prdata;
	wire                   o_pready;
	wire                   o_pslverr;
	wire                   o_core_rst_n;
	wire                   o_mbox_irq;
	wire  [LED_W-1:0]      o_led;

	row_t                  rows[$];
	logic [APB_DATA_W-1:0] pushed[$];
	integer                seed;
	int                    checks;
	int                    errors;
	int                    timeouts;

	sysctl_subsys DUT (.*);

	always #50 core_clk = ~core_clk;

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	// called on a falling edge and returns on the falling edge after the access phase
	task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [APB_DATA_W-1:0] wdata, output logic [APB_DATA_W-1:0] rdata,
		output logic err);
		int waited;
		waited = 0;
		rdata = '0;
		err = 1'b0;
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = wr;
		i_paddr = addr;
		i_pwdata = wdata;
		@(negedge core_clk);
		i_penable = 1'b1;
		@(posedge core_clk);
		while (!o_pready && waited < 16) begin
			waited++;
			@(posedge core_clk);
		end
		if (!o_pready) begin
			timeouts++;
			$display("timeout waiting for pready at address 0x%03h", addr);
		end else begin
			rdata = o_prdata;
			err = o_pslverr;
		end
		@(negedge core_clk);
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
		input logic [APB_DATA_W-1:0] data, output logic err);
		logic [APB_DATA_W-1:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
		output logic [APB_DATA_W-1:0] data, output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic add_row(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, input logic [31:0] rdata, input logic err);
		rows.push_back('{wr, addr, wdata, rdata, err});
	endtask

	task automatic wait_core_level(input logic level, input int max_n);
		int n;
		n = 0;
		while (o_core_rst_n !== level && n < max_n) begin
			n++;
			@(negedge core_clk);
		end
		if (o_core_rst_n !== level) begin
			timeouts++;
			$display("timeout waiting for o_core_rst_n to become %0b", level);
		end
	endtask

	// falling edges in a row with o_core_rst_n at the given level
	task automatic count_run(input logic level, input int max_n, output int n);
		n = 0;
		while (o_core_rst_n === level && n < max_n) begin
			n++;
			@(negedge core_clk);
		end
	endtask

	initial begin
		logic [APB_DATA_W-1:0] rdata;
		logic [APB_DATA_W-1:0] word;
		logic err;
		int n;
		core_clk = 1'b0;
		rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		seed = 32'h412d_b60c;
		checks = 0;
		errors = 0;
		timeouts = 0;
		repeat (8) @(negedge core_clk);
		rst_n = 1'b1;
		expect_equal("o_core_rst_n", o_core_rst_n, 0);
		expect_equal("o_led", o_led, 0);
		expect_equal("o_pready", o_pready, 0);
		expect_equal("o_pslverr", o_pslverr, 0);
		expect_equal("o_mbox_irq", o_mbox_irq, 0);
		wait_core_level(1'b1, IDLE_RESET_VAL + 1 + 10);
		apb_read(A_STATUS, rdata, err);
		expect_equal("STATUS[0]", rdata[0], 0);

		// register table where only the low 4 LED bits are kept
		add_row(1, A_LED, 32'h0000_00A5, 0, 0);
		add_row(0, A_LED, 0, 32'h0000_0005, 0);
		add_row(1, A_IDLE, 32'h0000_1234, 0, 0);
		add_row(0, A_IDLE, 0, 32'h0000_1234, 0);
		add_row(1, A_ACTIVE, 32'h00C0_FFEE, 0, 0);
		add_row(0, A_ACTIVE, 0, 32'h00C0_FFEE, 0);
		add_row(1, A_ACTIVE, 32'h0, 0, 0);
		add_row(0, A_ACTIVE, 0, 32'h0, 0);
		add_row(1, A_IDLE, 32'h0000_0002, 0, 0);
		add_row(0, A_IDLE, 0, 32'h0000_0002, 0);
		add_row(1, A_RESET, 32'hFFFF_FFFF, 0, 0);
		add_row(0, A_RESET, 0, 32'h0, 0);
		add_row(1, A_STATUS, 32'h1, 0, 1);
		add_row(1, SYSCTL_BASE + 12'h014, 32'h1, 0, 1);
		add_row(0, SYSCTL_BASE + 12'h0FC, 0, 32'h0, 1);
		foreach (rows[i]) begin
			if (rows[i].wr) begin
				apb_write(rows[i].addr, rows[i].wdata, err);
			end else begin
				apb_read(rows[i].addr, rdata, err);
				expect_equal("o_prdata", rdata, rows[i].rdata);
			end
			expect_equal("o_pslverr", err, rows[i].err);
		end
		expect_equal("o_led", o_led, 4'h5);
		wait_core_level(1'b1, 20);

		// software reset with IDLE=5 gives a hold of 6 cycles
		apb_write(A_IDLE, 32'd5, err);
		apb_write(A_RESET, 32'h0, err);
		expect_equal("o_core_rst_n", o_core_rst_n, 1);
		@(negedge core_clk);
		expect_equal("o_core_rst_n", o_core_rst_n, 0);
		count_run(1'b0, 50, n);
		expect_equal("o_core_rst_n low cycles", n, 6);
		apb_write(A_RESET, 32'h0, err);
		apb_read(A_STATUS, rdata, err);
		expect_equal("STATUS[0]", rdata[0], 1);
		wait_core_level(1'b1, 20);
		apb_read(A_STATUS, rdata, err);
		expect_equal("STATUS[0]", rdata[0], 0);

		// active window of ACTIVE+1 cycles followed by IDLE+1 cycles in reset
		apb_write(A_IDLE, 32'd3, err);
		apb_write(A_ACTIVE, 32'd20, err);
		wait_core_level(1'b0, 40);
		count_run(1'b0, 50, n);
		expect_equal("o_core_rst_n low cycles", n, 4);
		count_run(1'b1, 50, n);
		expect_equal("o_core_rst_n high cycles", n, 21);
		count_run(1'b0, 50, n);
		expect_equal("o_core_rst_n low cycles", n, 4);
		apb_write(A_ACTIVE, 32'd0, err);
		count_run(1'b1, 60, n);
		expect_equal("o_core_rst_n high cycles", n, 60);

		// mailbox fill, overflow, drain in order, underflow
		for (int i = 0; i < 8; i++) begin
			word = $random(seed);
			pushed.push_back(word);
			apb_write(A_MDATA, word, err);
			expect_equal("o_pslverr", err, 0);
		end
		apb_write(A_MDATA, $random(seed), err);
		expect_equal("o_pslverr", err, 1);
		apb_read(A_MSTAT, rdata, err);
		expect_equal("MBOX_STAT", rdata, 32'h0000_0208);
		expect_equal("o_mbox_irq", o_mbox_irq, 1);
		while (pushed.size() > 0) begin
			apb_read(A_MDATA, rdata, err);
			expect_equal("o_prdata", rdata, pushed.pop_front());
			expect_equal("o_pslverr", err, 0);
		end
		apb_read(A_MDATA, rdata, err);
		expect_equal("o_prdata", rdata, 0);
		expect_equal("o_pslverr", err, 1);
		expect_equal("o_mbox_irq", o_mbox_irq, 0);

		// unmapped region
		apb_write(12'h300, 32'hFFFF_FFFF, err);
		expect_equal("o_pslverr", err, 1);
		apb_read(12'h300, rdata, err);
		expect_equal("o_prdata", rdata, 0);
		expect_equal("o_pslverr", err, 1);
		apb_read(A_LED, rdata, err);
		expect_equal("LED", rdata, 32'h5);
		apb_read(A_IDLE, rdata, err);
		expect_equal("IDLE", rdata, 32'd3);
		apb_read(A_MSTAT, rdata, err);
		expect_equal("MBOX_STAT", rdata, 32'h0000_0100);
		expect_equal("o_led", o_led, 4'h5);

		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/sysctl_map_pkg.sv
verilog/rst_seq_pkg.sv
verilog/apb_region_decoder.sv
verilog/sysctl_regs.sv
verilog/cycle_counter.sv
verilog/core_rst_sequencer.sv
verilog/apb_mailbox.sv
verilog/sysctl_subsys.sv
test/sysctl_assertions.sv
test/tb_sysctl_subsys.sv
